/* replica_pkg.sv */
`default_nettype none

package replica_pkg;

    localparam int city_num = 8;
    localparam int city_log = 3;
    localparam int dist_w   = 8;
    localparam int total_w  = 12;
    localparam int slot_num = city_num + 1;     // 8 tour entries, then the total
    localparam int slot_log = 4;

    typedef logic [city_log-1:0]  city_t;
    typedef logic [dist_w-1:0]    dist_t;
    typedef logic [total_w-1:0]   total_t;
    typedef city_t [city_num-1:0] tour_t;       // position 0 in the low bits

    // one word of the load and unload streams
    typedef union packed {
        struct packed {
            logic [15-city_log:0] unused;
            city_t                city;
        } entry;
        struct packed {
            logic [15-total_w:0] unused;
            total_t              total;
        } sum;
    } link_word_t;

    typedef struct packed {
        city_t       pos;                       // swaps pos and pos+1
        logic [15:0] rnd;                       // acceptance random value
    } move_t;

endpackage

`default_nettype wire

/* move_random.sv */
`default_nettype none

module move_random #(
    parameter logic [63:0] seed_base = 64'h0123_4567_89ab_cdef,
    parameter int          index     = 0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          step,
    output replica_pkg::move_t move
);

    localparam logic [63:0] seed = seed_base ^ (64'(index + 1) * 64'h9e37_79b9_7f4a_7c15);

    logic [63:0] state;
    logic [63:0] x1;
    logic [63:0] x2;
    logic [63:0] x3;

    always_comb begin
        x1 = state ^ (state << 13);
        x2 = x1 ^ (x1 >> 7);
        x3 = x2 ^ (x2 << 17);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= (seed == '0) ? 64'h1 : seed;   // all zero would lock up
        end else if (step) begin
            state <= x3;
        end
    end

    assign move.pos = replica_pkg::city_t'(state % replica_pkg::city_num);
    assign move.rnd = state[replica_pkg::city_log +: 16];

endmodule

`default_nettype wire

/* dist_table.sv */
`default_nettype none

module dist_table (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    dist_write,
    input  wire logic [2*replica_pkg::city_log-1:0]      dist_waddr,
    input  wire replica_pkg::dist_t                      dist_wdata,
    input  wire logic [3:0][2*replica_pkg::city_log-1:0] raddr,
    output replica_pkg::dist_t [3:0]                     rdata
);

    localparam int depth = replica_pkg::city_num * replica_pkg::city_num;
    localparam int cl    = replica_pkg::city_log;

    replica_pkg::dist_t mem [depth];

    always_ff @(posedge clk) begin
        if (dist_write) begin
            mem[dist_waddr] <= dist_wdata;          // row in the high bits
        end
        for (int i = 0; i < 4; i++) begin
            rdata[i] <= mem[raddr[i]];
        end
    end

    // a self distance would skew every delta that touches the diagonal
    a_zero_diag: assert property (@(posedge clk) disable iff (!rst_n)
        dist_write && dist_waddr[2*cl-1:cl] == dist_waddr[cl-1:0] |-> dist_wdata == '0);

endmodule

`default_nettype wire

/* tour_delta.sv */
`default_nettype none

module tour_delta (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               in_valid,
    input  wire replica_pkg::city_t                 pos,
    input  wire replica_pkg::dist_t [3:0]           rdata,
    output logic                                    out_valid,
    output logic signed [replica_pkg::total_w:0]    delta
);

    // rdata order: d(a,c), d(b,d), d(a,b), d(c,d)
    replica_pkg::total_t added_q;
    replica_pkg::total_t removed_q;
    logic                valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            added_q   <= replica_pkg::total_t'(rdata[0]) + replica_pkg::total_t'(rdata[1]);
            removed_q <= replica_pkg::total_t'(rdata[2]) + replica_pkg::total_t'(rdata[3]);
        end
    end

    assign out_valid = valid_q;
    assign delta     = $signed({1'b0, added_q}) - $signed({1'b0, removed_q});   // stage 2

endmodule

`default_nettype wire

/* replica_node.sv */
`default_nettype none

module replica_node #(
    parameter int          index      = 0,
    parameter int          temp_shift = 4,
    parameter logic [63:0] seed_base  = 64'h1
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               dist_write,
    input  wire logic [2*replica_pkg::city_log-1:0] dist_waddr,
    input  wire replica_pkg::dist_t                 dist_wdata,
    input  wire logic                               slot_we,
    input  wire logic [replica_pkg::slot_log-1:0]   slot_idx,
    input  wire replica_pkg::link_word_t            slot_word,
    input  wire logic                               run,
    input  wire logic [15:0]                        run_steps,
    input  wire logic                               exchange,
    input  wire logic                               exchange_phase_even,
    input  wire replica_pkg::total_t                folw_total,
    input  wire replica_pkg::tour_t                 folw_tour,
    input  wire replica_pkg::total_t                prev_total,
    input  wire replica_pkg::tour_t                 prev_tour,
    input  wire logic                               swap_in,
    output logic                                    swap_out,
    output replica_pkg::tour_t                      tour,
    output replica_pkg::total_t                     total,
    output logic                                    busy
);

    localparam int tw = replica_pkg::total_w;

    replica_pkg::move_t                      mv;
    replica_pkg::move_t                      mv_q;
    replica_pkg::city_t                      a;
    replica_pkg::city_t                      b;
    replica_pkg::city_t                      c;
    replica_pkg::city_t                      d;
    logic [3:0][2*replica_pkg::city_log-1:0] raddr;
    replica_pkg::dist_t [3:0]                rdata;
    logic [15:0]                             moves_left;
    logic [1:0]                              step_cnt;
    logic                                    issue;
    logic                                    issue_q;
    logic                                    delta_valid;
    logic signed [tw:0]                      delta;
    logic signed [tw:0]                      new_total;
    logic [16:0]                             thresh;
    logic                                    accept;
    logic                                    lead;

    assign issue = busy && step_cnt == 2'd0;    // one move per 3 cycles

    move_random #(.seed_base(seed_base), .index(index)) random_i (
        .clk  (clk),
        .rst_n(rst_n),
        .step (issue),
        .move (mv)
    );

    always_comb begin
        a = tour[replica_pkg::city_t'(mv.pos - 1)];
        b = tour[mv.pos];
        c = tour[replica_pkg::city_t'(mv.pos + 1)];
        d = tour[replica_pkg::city_t'(mv.pos + 2)];
    end

    assign raddr[0] = {a, c};                   // added edges
    assign raddr[1] = {b, d};
    assign raddr[2] = {a, b};                   // removed edges
    assign raddr[3] = {c, d};

    dist_table table_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dist_write(dist_write),
        .dist_waddr(dist_waddr),
        .dist_wdata(dist_wdata),
        .raddr     (raddr),
        .rdata     (rdata)
    );

    tour_delta delta_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (issue_q),
        .pos      (mv_q.pos),
        .rdata    (rdata),
        .out_valid(delta_valid),
        .delta    (delta)
    );

    assign thresh    = 17'({1'b0, mv_q.rnd} >> temp_shift);
    assign accept    = delta_valid && (delta <= 0 || 17'(delta[tw-1:0]) < thresh);
    assign new_total = $signed({1'b0, total}) + delta;
    assign lead      = ((index % 2) == 0) == exchange_phase_even;   // colder side of a pair

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            moves_left <= '0;
            step_cnt   <= '0;
            issue_q    <= 1'b0;
            swap_out   <= 1'b0;
        end else begin
            issue_q  <= issue;
            swap_out <= exchange && !busy && lead && total > folw_total;
            if (!busy) begin
                step_cnt <= '0;
                if (run && run_steps != '0) begin
                    busy       <= 1'b1;
                    moves_left <= run_steps;
                end
            end else if (step_cnt == 2'd2) begin
                step_cnt   <= '0;
                moves_left <= moves_left - 1'b1;
                busy       <= moves_left != 16'd1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mv_q <= mv;
        end
        if (slot_we) begin
            if (slot_idx == replica_pkg::slot_log'(replica_pkg::city_num)) begin
                total <= slot_word.sum.total;
            end else begin
                tour[replica_pkg::city_t'(slot_idx)] <= slot_word.entry.city;
            end
        end else if (swap_out) begin
            tour  <= folw_tour;
            total <= folw_total;
        end else if (swap_in) begin
            tour  <= prev_tour;
            total <= prev_total;
        end else if (accept) begin
            tour[mv_q.pos]                            <= tour[replica_pkg::city_t'(mv_q.pos + 1)];
            tour[replica_pkg::city_t'(mv_q.pos + 1)]  <= tour[mv_q.pos];
            total                                     <= replica_pkg::total_t'(new_total);
        end
    end

    a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
        slot_we |-> !busy);

    a_total_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !new_total[tw]);

endmodule

`default_nettype wire

/* ring_loader.sv */
`default_nettype none

module ring_loader #(
    parameter int replica_num = 4
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             load_valid,
    input  wire replica_pkg::link_word_t          load_word,
    output logic [replica_num-1:0]                slot_we,
    output logic [replica_pkg::slot_log-1:0]      slot_idx,
    output replica_pkg::link_word_t               slot_word
);

    localparam int rep_w = replica_num > 1 ? $clog2(replica_num) : 1;

    logic [rep_w-1:0]                rep_cnt;
    logic [replica_pkg::slot_log-1:0] slot_cnt;
    logic                            last_slot;
    logic                            last_rep;

    assign last_slot = slot_cnt == replica_pkg::slot_log'(replica_pkg::slot_num - 1);
    assign last_rep  = rep_cnt == rep_w'(replica_num - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rep_cnt  <= '0;
            slot_cnt <= '0;
            slot_we  <= '0;
        end else begin
            slot_we <= '0;
            if (load_valid) begin
                slot_we  <= replica_num'(1) << rep_cnt;   // one-hot replica
                slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
                if (last_slot) begin
                    rep_cnt <= last_rep ? '0 : rep_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            slot_idx  <= slot_cnt;
            slot_word <= load_word;
        end
    end

endmodule

`default_nettype wire

/* ring_unloader.sv */
`default_nettype none

module ring_unloader #(
    parameter int replica_num = 4
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  unload,
    input  wire replica_pkg::tour_t [replica_num-1:0]  tour,
    input  wire replica_pkg::total_t [replica_num-1:0] total,
    output logic                                       out_valid,
    output replica_pkg::link_word_t                    out_word
);

    localparam int rep_w = replica_num > 1 ? $clog2(replica_num) : 1;

    logic [rep_w-1:0]                 rep_cnt;
    logic [replica_pkg::slot_log-1:0] slot_cnt;
    logic                             last_slot;
    logic                             last_rep;

    assign last_slot = slot_cnt == replica_pkg::slot_log'(replica_pkg::slot_num - 1);
    assign last_rep  = rep_cnt == rep_w'(replica_num - 1);

    // counters rest at zero, so a pulse only needs to raise out_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rep_cnt   <= '0;
            slot_cnt  <= '0;
        end else if (!out_valid) begin
            out_valid <= unload;
        end else begin
            slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
            if (last_slot) begin
                rep_cnt <= last_rep ? '0 : rep_cnt + 1'b1;
                if (last_rep) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        out_word = '0;
        if (slot_cnt == replica_pkg::slot_log'(replica_pkg::city_num)) begin
            out_word.sum.total = total[rep_cnt];
        end else begin
            out_word.entry.city = tour[rep_cnt][replica_pkg::city_t'(slot_cnt)];
        end
    end

endmodule

`default_nettype wire

/* replica_ring.sv */
`default_nettype none

module replica_ring #(
    parameter int          replica_num = 4,
    parameter logic [63:0] seed_base   = 64'h2545_f491_4f6c_dd1d
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               dist_write,
    input  wire logic [2*replica_pkg::city_log-1:0] dist_waddr,
    input  wire replica_pkg::dist_t                 dist_wdata,
    input  wire logic                               load_valid,
    input  wire replica_pkg::link_word_t            load_word,
    input  wire logic                               run,
    input  wire logic [15:0]                        run_steps,
    input  wire logic                               exchange,
    input  wire logic                               exchange_phase,     // 0 even, 1 odd
    input  wire logic                               unload,
    output logic                                    out_valid,
    output replica_pkg::link_word_t                 out_word,
    output logic                                    busy
);

    logic [replica_num-1:0]                 slot_we;
    logic [replica_pkg::slot_log-1:0]       slot_idx;
    replica_pkg::link_word_t                slot_word;
    replica_pkg::tour_t [replica_num-1:0]   tour;
    replica_pkg::total_t [replica_num-1:0]  total;
    logic [replica_num-1:0]                 node_busy;
    logic [replica_num-1:0]                 swap;

    ring_loader #(.replica_num(replica_num)) loader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_valid(load_valid),
        .load_word (load_word),
        .slot_we   (slot_we),
        .slot_idx  (slot_idx),
        .slot_word (slot_word)
    );

    for (genvar i = 0; i < replica_num; i++) begin : g_rep
        replica_pkg::total_t folw_total;
        replica_pkg::tour_t  folw_tour;
        replica_pkg::total_t prev_total;
        replica_pkg::tour_t  prev_tour;
        logic                swap_in;

        if (i + 1 < replica_num) begin : g_folw
            assign folw_total = total[i+1];
            assign folw_tour  = tour[i+1];
        end else begin : g_last
            assign folw_total = '1;                 // no follower, never swaps
            assign folw_tour  = '0;
        end

        if (i > 0) begin : g_prev
            assign prev_total = total[i-1];
            assign prev_tour  = tour[i-1];
            assign swap_in    = swap[i-1];
        end else begin : g_first
            assign prev_total = '0;
            assign prev_tour  = '0;
            assign swap_in    = 1'b0;
        end

        replica_node #(
            .index     (i),
            .temp_shift(i == 0 ? 16 : (i < 8 ? 9 - i : 1)),   // replica 0 greedy
            .seed_base (seed_base)
        ) node_i (
            .clk                (clk),
            .rst_n              (rst_n),
            .dist_write         (dist_write),
            .dist_waddr         (dist_waddr),
            .dist_wdata         (dist_wdata),
            .slot_we            (slot_we[i]),
            .slot_idx           (slot_idx),
            .slot_word          (slot_word),
            .run                (run),
            .run_steps          (run_steps),
            .exchange           (exchange),
            .exchange_phase_even(!exchange_phase),
            .folw_total         (folw_total),
            .folw_tour          (folw_tour),
            .prev_total         (prev_total),
            .prev_tour          (prev_tour),
            .swap_in            (swap_in),
            .swap_out           (swap[i]),
            .tour               (tour[i]),
            .total              (total[i]),
            .busy               (node_busy[i])
        );
    end

    ring_unloader #(.replica_num(replica_num)) unloader_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .unload   (unload),
        .tour     (tour),
        .total    (total),
        .out_valid(out_valid),
        .out_word (out_word)
    );

    assign busy = |node_busy;

endmodule

`default_nettype wire

/* replica_ring_tb.sv */
`default_nettype none

module replica_ring_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int replica_num = 4;
    localparam int cn          = replica_pkg::city_num;
    localparam int sn          = replica_pkg::slot_num;
    localparam int op_dist     = 0;
    localparam int op_load     = 1;
    localparam int op_run      = 2;
    localparam int op_exchange = 3;
    localparam int op_unload   = 4;
    localparam int step_num    = 13;

    typedef struct {
        int op;
        int arg;        // moves for a run, phase for an exchange
        int expected;   // busy cycles for a run, 1 for an exact unload
    } step_t;

    logic                               clk = 1'b0;
    logic                               rst_n = 1'b0;
    logic                               dist_write;
    logic [2*replica_pkg::city_log-1:0] dist_waddr;
    replica_pkg::dist_t                 dist_wdata;
    logic                               load_valid;
    replica_pkg::link_word_t            load_word;
    logic                               run;
    logic [15:0]                        run_steps;
    logic                               exchange;
    logic                               exchange_phase;
    logic                               unload;
    logic                               out_valid;
    replica_pkg::link_word_t            out_word;
    logic                               busy;

    step_t               steps [step_num];
    replica_pkg::dist_t  dist_mat [cn][cn];
    replica_pkg::tour_t  model_tour [replica_num];
    replica_pkg::total_t model_total [replica_num];
    replica_pkg::tour_t  got_tour [replica_num];
    replica_pkg::total_t got_total [replica_num];
    replica_pkg::total_t pre_run_total;
    logic [31:0]         lfsr = 32'h5a5b_39c1;
    int                  city_errs = 0;
    int                  total_errs = 0;
    int                  other_errs = 0;
    int                  budget = 10;   // reset and settling
    logic                budget_ready = 1'b0;

    always #5 clk = ~clk;

    replica_ring #(.replica_num(replica_num)) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .dist_write    (dist_write),
        .dist_waddr    (dist_waddr),
        .dist_wdata    (dist_wdata),
        .load_valid    (load_valid),
        .load_word     (load_word),
        .run           (run),
        .run_steps     (run_steps),
        .exchange      (exchange),
        .exchange_phase(exchange_phase),
        .unload        (unload),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .busy          (busy)
    );

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic replica_pkg::total_t tour_length(input replica_pkg::tour_t t);
        replica_pkg::total_t sum;
        sum = '0;
        for (int p = 0; p < cn; p++) begin
            sum = sum + replica_pkg::total_t'(dist_mat[t[p]][t[(p + 1) % cn]]);  // closed tour
        end
        return sum;
    endfunction

    function automatic logic is_permutation(input replica_pkg::tour_t t);
        logic [cn-1:0] seen;
        seen = '0;
        for (int p = 0; p < cn; p++) begin
            seen[t[p]] = 1'b1;
        end
        return seen == '1;
    endfunction

    function automatic int step_cycles(input step_t s);
        case (s.op)
            op_dist:     return cn * cn + 2;
            op_run:      return 3 * s.arg + 4;
            op_exchange: return 4;
            default:     return replica_num * sn + 4;     // load and unload
        endcase
    endfunction

    task automatic check_city(input string name, input replica_pkg::city_t got,
                              input replica_pkg::city_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            city_errs++;
        end
    endtask

    task automatic check_total(input string name, input replica_pkg::total_t got,
                               input replica_pkg::total_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            total_errs++;
        end
    endtask

    task automatic write_distances();
        for (int r = 0; r < cn; r++) begin
            dist_mat[r][r] = '0;
            for (int c = r + 1; c < cn; c++) begin
                dist_mat[r][c] = replica_pkg::dist_t'(take_bits(replica_pkg::dist_w));
                dist_mat[c][r] = dist_mat[r][c];        // symmetric
            end
        end
        for (int a = 0; a < cn * cn; a++) begin
            @(negedge clk);
            dist_write = 1'b1;
            dist_waddr = 6'(a);                          // row then column
            dist_wdata = dist_mat[a / cn][a % cn];
        end
        @(negedge clk);
        dist_write = 1'b0;
    endtask

    task automatic load_tours();
        replica_pkg::link_word_t w;
        replica_pkg::city_t      tmp;
        int                      j;
        for (int r = 0; r < replica_num; r++) begin
            for (int p = 0; p < cn; p++) begin
                model_tour[r][p] = replica_pkg::city_t'(p);
            end
            for (int p = cn - 1; p > 0; p--) begin      // shuffle
                j = int'(take_bits(4)) % (p + 1);
                tmp = model_tour[r][p];
                model_tour[r][p] = model_tour[r][j];
                model_tour[r][j] = tmp;
            end
            model_total[r] = tour_length(model_tour[r]);
        end
        for (int r = 0; r < replica_num; r++) begin
            for (int s = 0; s < sn; s++) begin
                w = '0;
                if (s == cn) begin
                    w.sum.total = model_total[r];
                end else begin
                    w.entry.city = model_tour[r][s];
                end
                @(negedge clk);
                load_valid = 1'b1;
                load_word  = w;
            end
        end
        @(negedge clk);
        load_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_moves(input int n, input int exp_cycles);
        int cycles;
        pre_run_total = model_total[0];
        @(negedge clk);
        run       = 1'b1;
        run_steps = 16'(n);
        cycles    = 0;
        do begin
            @(negedge clk);
            run = 1'b0;
            cycles++;
        end while (busy && cycles < exp_cycles + 8);
        if (busy) begin
            $display("busy still high %0d cycles after run", cycles);
            other_errs++;
        end else if (cycles != exp_cycles) begin
            $display("busy fell %0d cycles after run instead of %0d", cycles, exp_cycles);
            other_errs++;
        end
    endtask

    task automatic exchange_pass(input int phase);
        replica_pkg::tour_t  t;
        replica_pkg::total_t s;
        @(negedge clk);
        exchange       = 1'b1;
        exchange_phase = phase[0];
        @(negedge clk);
        exchange = 1'b0;
        repeat (2) @(negedge clk);
        for (int i = phase; i + 1 < replica_num; i += 2) begin
            if (model_total[i] > model_total[i + 1]) begin  // colder holds the longer tour
                t = model_tour[i];
                s = model_total[i];
                model_tour[i]      = model_tour[i + 1];
                model_total[i]     = model_total[i + 1];
                model_tour[i + 1]  = t;
                model_total[i + 1] = s;
            end
        end
    endtask

    task automatic unload_words(input int exact);
        @(negedge clk);
        unload = 1'b1;
        @(negedge clk);
        unload = 1'b0;
        for (int r = 0; r < replica_num; r++) begin
            for (int s = 0; s < sn; s++) begin
                if (!out_valid) begin
                    $display("out_valid low at word %0d of the unload", r * sn + s);
                    other_errs++;
                end
                if (s == cn) begin
                    got_total[r] = out_word.sum.total;
                end else begin
                    got_tour[r][s] = out_word.entry.city;
                end
                @(negedge clk);
            end
        end
        if (out_valid) begin
            $display("out_valid still high after the last word");
            other_errs++;
        end
        for (int r = 0; r < replica_num; r++) begin
            if (exact != 0) begin
                for (int p = 0; p < cn; p++) begin
                    check_city($sformatf("tour[%0d][%0d]", r, p), got_tour[r][p],
                               model_tour[r][p]);
                end
                check_total($sformatf("total[%0d]", r), got_total[r], model_total[r]);
            end else begin
                if (!is_permutation(got_tour[r])) begin
                    $display("replica %0d tour is not a permutation of the cities", r);
                    other_errs++;
                end
                check_total($sformatf("total[%0d]", r), got_total[r], tour_length(got_tour[r]));
                model_tour[r]  = got_tour[r];
                model_total[r] = got_total[r];
            end
        end
        if (exact == 0 && got_total[0] > pre_run_total) begin
            $display("replica 0 total rose from %0d to %0d in a greedy run",
                     pre_run_total, got_total[0]);
            other_errs++;
        end
    endtask

    initial begin
        dist_write     = 1'b0;
        dist_waddr     = '0;
        dist_wdata     = '0;
        load_valid     = 1'b0;
        load_word      = '0;
        run            = 1'b0;
        run_steps      = '0;
        exchange       = 1'b0;
        exchange_phase = 1'b0;
        unload         = 1'b0;
        steps[0]  = '{op_dist, 0, 0};
        steps[1]  = '{op_load, 0, 0};
        steps[2]  = '{op_unload, 0, 1};
        steps[3]  = '{op_run, 20, 61};
        steps[4]  = '{op_unload, 0, 0};
        steps[5]  = '{op_exchange, 0, 0};
        steps[6]  = '{op_unload, 0, 1};
        steps[7]  = '{op_exchange, 1, 0};
        steps[8]  = '{op_unload, 0, 1};
        steps[9]  = '{op_run, 40, 121};
        steps[10] = '{op_unload, 0, 0};
        steps[11] = '{op_exchange, 0, 0};
        steps[12] = '{op_unload, 0, 1};
        for (int i = 0; i < step_num; i++) begin
            budget += step_cycles(steps[i]);
        end
        budget_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (busy || out_valid) begin
            $display("busy or out_valid high after reset");
            other_errs++;
        end
        for (int i = 0; i < step_num; i++) begin
            case (steps[i].op)
                op_dist:     write_distances();
                op_load:     load_tours();
                op_run:      run_moves(steps[i].arg, steps[i].expected);
                op_exchange: exchange_pass(steps[i].arg);
                default:     unload_words(steps[i].expected);
            endcase
        end
        $display("errors: city %0d, total %0d, other %0d", city_errs, total_errs, other_errs);
        if (city_errs + total_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (budget_ready);
        repeat (4 * budget) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", 4 * budget);
        $display("errors: city %0d, total %0d, other %0d", city_errs, total_errs, other_errs);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* replica_ring.f */
replica_pkg.sv
move_random.sv
dist_table.sv
tour_delta.sv
replica_node.sv
ring_loader.sv
ring_unloader.sv
replica_ring.sv
replica_ring_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := replica_ring_tb
FILELIST  := replica_ring.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Something failed
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
